/* softusb_macros.svh */
`ifndef SOFTUSB_MACROS_SVH
`define SOFTUSB_MACROS_SVH

// Transmit queue depth in bytes
// Power of two keeps the pointer logic small
`define SOFTUSB_FIFO_DEPTH 16

// usb_clk cycles per line bit
// 48 MHz clock against 12 Mbit/s full speed
`define SOFTUSB_BIT_CYCLES 4

// Consecutive ones after which a zero is stuffed
`define SOFTUSB_STUFF_LIMIT 6

// Consecutive SE0 cycles that mark a disconnect
// Roughly 2.6 us at 48 MHz
`define SOFTUSB_DISCON_CYCLES 127

`endif

/* softusb_pkg.sv */
`default_nettype none

package softusb_pkg;

	// One packet byte as it moves through the queue and the serializer
	typedef logic [7:0] usb_byte_t;

	// Line state as seen by the receivers
	// Upper bit is vm, lower bit is vp
	typedef logic [1:0] line_state_t;

	// Single ended zero, both lines low
	localparam line_state_t LS_SE0 = 2'b00;
	// Idle state of a full speed line
	localparam line_state_t LS_J   = 2'b01;
	localparam line_state_t LS_K   = 2'b10;

	// One queue entry
	// Last flag marks the final byte of a packet
	typedef struct packed {
		usb_byte_t data;
		logic      last;
	} tx_entry_t;

	// Transmit port selection, one enable bit per port
	typedef logic [1:0] port_sel_t;

	// Bit positions inside port_sel_t
	localparam int PORT_A = 0;
	localparam int PORT_B = 1;

endpackage

`default_nettype wire

/* softusb_byte_if.sv */
`timescale 1ns/10ps
`default_nettype none

// Byte stream from the transmit queue to the serializer
// Transfer on any cycle with valid and ready both high
interface softusb_byte_if import softusb_pkg::*; ();

	// Payload of the current head entry
	usb_byte_t data;
	// Head byte closes its packet
	logic      last;
	// Head entry present, held until taken
	logic      valid;
	// Serializer takes the head entry
	logic      ready;

	// Queue side
	modport source (
		output data,
		output last,
		output valid,
		input  ready
	);

	// Serializer side
	modport sink (
		input  data,
		input  last,
		input  valid,
		output ready
	);

endinterface

`default_nettype wire

/* softusb_filter.sv */
`timescale 1ns/10ps
`default_nettype none

// Brings the asynchronous vp/vm pins of one port into usb_clk
// Line state follows the pins two cycles later
module softusb_filter import softusb_pkg::*; (
	input  wire logic  usb_clk,

	input  wire logic  vp,
	input  wire logic  vm,

	output line_state_t line_state
);

	// First stage, may go metastable
	logic vp_meta;
	logic vm_meta;

	// First stage samples the raw pins
	always_ff @(posedge usb_clk) begin
		vp_meta <= vp;
		vm_meta <= vm;
	end

	// Second stage settles the sample
	// Packed as {vm, vp} to match line_state_t
	always_ff @(posedge usb_clk) begin
		line_state <= {vm_meta, vp_meta};
	end

endmodule

`default_nettype wire

/* softusb_tx_fifo.sv */
`timescale 1ns/10ps
`default_nettype none
`include "softusb_macros.svh"

// Byte queue between the client and the serializer
// Each entry keeps its last flag so packet boundaries survive
module softusb_tx_fifo import softusb_pkg::*; (
	input  wire logic      usb_clk,
	input  wire logic      usb_rst,

	// Client write side
	input  wire usb_byte_t wr_data,
	input  wire logic      wr_last,
	input  wire logic      wr_valid,
	output logic           wr_ready,

	// Read side toward the serializer
	softusb_byte_if.source rd
);

	localparam int DEPTH = `SOFTUSB_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	// Entry storage
	tx_entry_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	// One bit wider than the pointers to tell full from empty
	logic [PTR_W:0]   count;

	logic push;
	logic pop;

	// Client is held only while the queue is full
	assign wr_ready = (count != (PTR_W+1)'(DEPTH));
	assign push     = wr_valid && wr_ready;

	// Head entry shows on the read side straight from storage
	assign rd.valid = (count != '0);
	assign rd.data  = mem[rd_ptr].data;
	assign rd.last  = mem[rd_ptr].last;
	assign pop      = rd.valid && rd.ready;

	always_ff @(posedge usb_clk) begin
		if (push) begin
			mem[wr_ptr] <= '{data: wr_data, last: wr_last};
		end
	end

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// Pointers wrap at the end of storage
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
			end
			// Push and pop together leave the count unchanged
			case ({push, pop})
				2'b10:   count <= count + (PTR_W+1)'(1);
				2'b01:   count <= count - (PTR_W+1)'(1);
				default: count <= count;
			endcase
		end
	end

	// Occupancy stays within storage
	a_count_bound: assert property (@(posedge usb_clk) disable iff (usb_rst)
		count <= (PTR_W+1)'(DEPTH));

endmodule

`default_nettype wire

/* softusb_tx.sv */
`timescale 1ns/10ps
`default_nettype none
`include "softusb_macros.svh"

// Full speed serializer
// LSB first, NRZI coded, zero stuffed after a run of ones, closed by EOP
// Also drives a bus reset while generate_reset is held
module softusb_tx import softusb_pkg::*; (
	input  wire logic    usb_clk,
	input  wire logic    usb_rst,

	softusb_byte_if.sink in,

	input  wire logic    generate_reset,

	output logic         txp,
	output logic         txm,
	output logic         txoe
);

	localparam int PHASE_W = $clog2(`SOFTUSB_BIT_CYCLES);
	localparam int ONES_W  = $clog2(`SOFTUSB_STUFF_LIMIT + 1);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_DATA,
		ST_EOP_SE0,
		ST_EOP_J,
		ST_BUS_RESET
	} tx_state_t;

	tx_state_t state;
	tx_state_t state_nxt;

	// Position inside the current bit period
	logic [PHASE_W-1:0] phase;
	logic               bit_end;

	// Bits of the current byte still to send, next one at bit 0
	logic [6:0]         rest;
	// Index of the data bit on the line
	logic [2:0]         bit_idx;
	logic               cur_last;

	// Byte taken early for a gapless stream
	usb_byte_t          nxt_data;
	logic               nxt_last;
	logic               nxt_valid;

	// Run of ones on the line, stuffing included
	logic [ONES_W-1:0]  ones;
	// NRZI level, 1 is J
	logic               level;
	logic               level_nxt;
	// Set during the second SE0 bit of an EOP
	logic               eop_half;

	logic               take;
	logic               stuff;
	logic               more_bits;
	logic               load_byte;
	logic               data_step;
	logic               send;
	logic               out_bit;
	usb_byte_t          next_byte;
	logic               next_is_last;

	assign bit_end = (phase == PHASE_W'(`SOFTUSB_BIT_CYCLES - 1));

	// Idle takes a new packet unless a bus reset is asked for
	// In data, the next byte is taken during the last bit
	assign in.ready = ((state == ST_IDLE) && !generate_reset) ||
		((state == ST_DATA) && (bit_idx == 3'd7) && !cur_last && !nxt_valid);
	assign take = in.valid && in.ready;

	always_comb begin
		// Byte taken on this very cycle counts as present
		next_byte    = nxt_valid ? nxt_data : in.data;
		next_is_last = nxt_valid ? nxt_last : in.last;
		stuff        = (ones == ONES_W'(`SOFTUSB_STUFF_LIMIT));
		more_bits    = (bit_idx != 3'd7);
		load_byte    = !cur_last && (nxt_valid || take);
		data_step    = (state == ST_DATA) && bit_end;
		send         = ((state == ST_IDLE) && take) ||
			(data_step && (stuff || more_bits || load_byte));

		// Bit that goes on the line next
		if (state == ST_IDLE) begin
			out_bit = in.data[0];
		end else if (stuff) begin
			out_bit = 1'b0;
		end else if (more_bits) begin
			out_bit = rest[0];
		end else begin
			out_bit = next_byte[0];
		end
	end

	always_comb begin
		state_nxt = state;
		level_nxt = level;
		case (state)
			ST_IDLE: begin
				if (generate_reset) begin
					state_nxt = ST_BUS_RESET;
				end else if (take) begin
					// NRZI starts from J, a zero moves to K
					state_nxt = ST_DATA;
					level_nxt = out_bit;
				end
			end
			ST_DATA: begin
				if (send) begin
					level_nxt = out_bit ? level : ~level;
				end else if (bit_end) begin
					// Last byte done, or underrun
					state_nxt = ST_EOP_SE0;
				end
			end
			ST_EOP_SE0: begin
				if (bit_end && eop_half) begin
					state_nxt = ST_EOP_J;
				end
			end
			ST_EOP_J: begin
				if (bit_end) begin
					state_nxt = ST_IDLE;
				end
			end
			ST_BUS_RESET: begin
				if (!generate_reset) begin
					state_nxt = ST_IDLE;
				end
			end
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			state     <= ST_IDLE;
			level     <= 1'b1;
			phase     <= '0;
			eop_half  <= 1'b0;
			ones      <= '0;
			nxt_valid <= 1'b0;
			txoe      <= 1'b0;
			txp       <= 1'b1;
			txm       <= 1'b0;
		end else begin
			state <= state_nxt;
			level <= level_nxt;

			// Bit pacing only runs while packet or EOP is on the line
			if ((state == ST_IDLE) || (state == ST_BUS_RESET) || bit_end) begin
				phase <= '0;
			end else begin
				phase <= phase + PHASE_W'(1);
			end

			if ((state == ST_EOP_SE0) && bit_end) begin
				eop_half <= ~eop_half;
			end

			if (send) begin
				if (!out_bit) begin
					ones <= '0;
				end else if (state == ST_IDLE) begin
					ones <= ONES_W'(1);
				end else begin
					ones <= ones + ONES_W'(1);
				end
			end

			// Early byte is held until its turn comes
			if (take && (state == ST_DATA)) begin
				nxt_valid <= 1'b1;
			end
			if (data_step && !stuff && !more_bits) begin
				nxt_valid <= 1'b0;
			end

			// Outputs follow the next state so txoe rises one cycle after the take
			txoe <= (state_nxt != ST_IDLE);
			case (state_nxt)
				ST_DATA: begin
					txp <= level_nxt;
					txm <= ~level_nxt;
				end
				ST_EOP_SE0, ST_BUS_RESET: begin
					txp <= 1'b0;
					txm <= 1'b0;
				end
				default: begin
					txp <= 1'b1;
					txm <= 1'b0;
				end
			endcase
		end
	end

	always_ff @(posedge usb_clk) begin
		if (take && (state == ST_DATA)) begin
			nxt_data <= in.data;
			nxt_last <= in.last;
		end
		if ((state == ST_IDLE) && take) begin
			// Bit 0 goes straight to the line
			rest     <= in.data[7:1];
			bit_idx  <= '0;
			cur_last <= in.last;
		end else if (data_step && !stuff) begin
			if (more_bits) begin
				rest    <= rest >> 1;
				bit_idx <= bit_idx + 3'd1;
			end else if (load_byte) begin
				rest     <= next_byte[7:1];
				bit_idx  <= '0;
				cur_last <= next_is_last;
			end
		end
	end

	// SE0 appears only in EOP or bus reset
	a_se0_state: assert property (@(posedge usb_clk) disable iff (usb_rst)
		(!txp && !txm) |-> ((state == ST_EOP_SE0) || (state == ST_BUS_RESET)));

	// Line released whenever the serializer is idle
	a_idle_oe: assert property (@(posedge usb_clk) disable iff (usb_rst)
		(state == ST_IDLE) |-> !txoe);

endmodule

`default_nettype wire

/* softusb_linemon.sv */
`timescale 1ns/10ps
`default_nettype none
`include "softusb_macros.svh"

// Disconnect detector for one port
// Flags an SE0 that lasts SOFTUSB_DISCON_CYCLES cycles or more
module softusb_linemon import softusb_pkg::*; (
	input  wire logic        usb_clk,
	input  wire logic        usb_rst,

	input  wire line_state_t line_state,

	output logic             discon
);

	localparam int CNT_W = $clog2(`SOFTUSB_DISCON_CYCLES + 1);

	// Consecutive SE0 cycles, stops at the limit
	logic [CNT_W-1:0] se0_cnt;
	logic             is_se0;
	logic             saturated;

	assign is_se0    = (line_state == LS_SE0);
	assign saturated = (se0_cnt == CNT_W'(`SOFTUSB_DISCON_CYCLES));

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			se0_cnt <= '0;
		end else if (!is_se0) begin
			// Any J or K restarts the run
			se0_cnt <= '0;
		end else if (!saturated) begin
			se0_cnt <= se0_cnt + CNT_W'(1);
		end
	end

	// Drops on the first cycle the line leaves SE0,
	// without waiting for the counter to clear
	assign discon = saturated && is_se0;

endmodule

`default_nettype wire

/* softusb_phy.sv */
`timescale 1ns/10ps
`default_nettype none

// Two port soft USB PHY, transmit path and line monitors
// Full speed only, receive decoding not present
module softusb_phy import softusb_pkg::*; (
	input  wire logic        usb_clk,
	input  wire logic        usb_rst,

	// Port A transceiver
	output logic             usba_spd,
	output logic             usba_oe_n,
	inout  wire              usba_vp,
	inout  wire              usba_vm,

	// Port B transceiver
	output logic             usbb_spd,
	output logic             usbb_oe_n,
	inout  wire              usbb_vp,
	inout  wire              usbb_vm,

	output logic             usba_discon,
	output logic             usbb_discon,

	output line_state_t      line_state_a,
	output line_state_t      line_state_b,

	input  wire port_sel_t   port_sel_tx,

	// Client byte stream
	input  wire usb_byte_t   tx_data,
	input  wire logic        tx_last,
	input  wire logic        tx_valid,
	output logic             tx_ready,

	input  wire logic        generate_reset
);

	logic txp;
	logic txm;
	logic txoe;
	logic txoe_a;
	logic txoe_b;

	// Queue to serializer
	softusb_byte_if tx_q ();

	// Line state per port, also seen by our own transmissions
	softusb_filter filter_a (
		.usb_clk    (usb_clk),
		.vp         (usba_vp),
		.vm         (usba_vm),
		.line_state (line_state_a)
	);

	softusb_filter filter_b (
		.usb_clk    (usb_clk),
		.vp         (usbb_vp),
		.vm         (usbb_vm),
		.line_state (line_state_b)
	);

	softusb_tx_fifo tx_fifo (
		.usb_clk  (usb_clk),
		.usb_rst  (usb_rst),
		.wr_data  (tx_data),
		.wr_last  (tx_last),
		.wr_valid (tx_valid),
		.wr_ready (tx_ready),
		.rd       (tx_q.source)
	);

	softusb_tx tx (
		.usb_clk        (usb_clk),
		.usb_rst        (usb_rst),
		.in             (tx_q.sink),
		.generate_reset (generate_reset),
		.txp            (txp),
		.txm            (txm),
		.txoe           (txoe)
	);

	// One serializer, fanned out to the selected ports
	assign txoe_a = txoe & port_sel_tx[PORT_A];
	assign txoe_b = txoe & port_sel_tx[PORT_B];

	// Transceiver enables are active low
	assign usba_oe_n = ~txoe_a;
	assign usbb_oe_n = ~txoe_b;

	// Pins released when not transmitting
	assign usba_vp = txoe_a ? txp : 1'bz;
	assign usba_vm = txoe_a ? txm : 1'bz;
	assign usbb_vp = txoe_b ? txp : 1'bz;
	assign usbb_vm = txoe_b ? txm : 1'bz;

	softusb_linemon linemon_a (
		.usb_clk    (usb_clk),
		.usb_rst    (usb_rst),
		.line_state (line_state_a),
		.discon     (usba_discon)
	);

	softusb_linemon linemon_b (
		.usb_clk    (usb_clk),
		.usb_rst    (usb_rst),
		.line_state (line_state_b),
		.discon     (usbb_discon)
	);

	// Full speed on both ports
	assign usba_spd = 1'b1;
	assign usbb_spd = 1'b1;

endmodule

`default_nettype wire

/* tb_softusb_phy.sv */
`timescale 1ns/10ps
`default_nettype none
`include "softusb_macros.svh"

module tb_softusb_phy import softusb_pkg::*; ();

	localparam int WAIT_LIMIT = 2000;
	localparam int MAX_BITS   = 1000;

	logic        usb_clk;
	logic        usb_rst;
	port_sel_t   port_sel_tx;
	usb_byte_t   tx_data;
	logic        tx_last;
	logic        tx_valid;
	logic        generate_reset;

	wire         usba_spd;
	wire         usba_oe_n;
	wire         usba_vp;
	wire         usba_vm;
	wire         usbb_spd;
	wire         usbb_oe_n;
	wire         usbb_vp;
	wire         usbb_vm;
	wire         usba_discon;
	wire         usbb_discon;
	wire         tx_ready;
	line_state_t line_state_a;
	line_state_t line_state_b;

	// Far end line level seen whenever the DUT releases the pins
	line_state_t drive_a;
	line_state_t drive_b;

	// Ports allowed to enable their transmitter
	logic        allow_a;
	logic        allow_b;
	logic        saw_full;
	// Unselected ports are watched for the far end's J
	logic        watch_unsel;

	// Command words from the data file
	logic [15:0] stim [0:255];
	usb_byte_t   exp_q [$];

	assign usba_vp = usba_oe_n ? drive_a[0] : 1'bz;
	assign usba_vm = usba_oe_n ? drive_a[1] : 1'bz;
	assign usbb_vp = usbb_oe_n ? drive_b[0] : 1'bz;
	assign usbb_vm = usbb_oe_n ? drive_b[1] : 1'bz;

	softusb_phy softusb_phy_inst (
		.usb_clk        (usb_clk),
		.usb_rst        (usb_rst),
		.usba_spd       (usba_spd),
		.usba_oe_n      (usba_oe_n),
		.usba_vp        (usba_vp),
		.usba_vm        (usba_vm),
		.usbb_spd       (usbb_spd),
		.usbb_oe_n      (usbb_oe_n),
		.usbb_vp        (usbb_vp),
		.usbb_vm        (usbb_vm),
		.usba_discon    (usba_discon),
		.usbb_discon    (usbb_discon),
		.line_state_a   (line_state_a),
		.line_state_b   (line_state_b),
		.port_sel_tx    (port_sel_tx),
		.tx_data        (tx_data),
		.tx_last        (tx_last),
		.tx_valid       (tx_valid),
		.tx_ready       (tx_ready),
		.generate_reset (generate_reset)
	);

	always #2 usb_clk = ~usb_clk;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1, "Stopping at first error");
	endtask

	task automatic compare_byte(input usb_byte_t got, input usb_byte_t exp, input string what);
		if (got !== exp) begin
			fail_run($sformatf("Mismatch at %0t: %s got %02h expected %02h",
				$time, what, got, exp));
		end
	endtask

	task automatic compare_state(input line_state_t got, input line_state_t exp,
		input string what);
		if (got !== exp) begin
			fail_run($sformatf("Mismatch at %0t: %s got %02b expected %02b",
				$time, what, got, exp));
		end
	endtask

	task automatic compare_count(input int got, input int exp, input string what);
		if (got != exp) begin
			fail_run($sformatf("Mismatch at %0t: %s got %0d expected %0d",
				$time, what, got, exp));
		end
	endtask

	// Pin pair of a port as {vm, vp}
	function automatic line_state_t pins(input int p);
		return (p == 0) ? {usba_vm, usba_vp} : {usbb_vm, usbb_vp};
	endfunction

	function automatic logic oe_n_of(input int p);
		return (p == 0) ? usba_oe_n : usbb_oe_n;
	endfunction

	function automatic logic discon_of(input int p);
		return (p == 0) ? usba_discon : usbb_discon;
	endfunction

	// Transmitter enabled on a port that was not selected
	always @(negedge usb_clk) begin
		if (!usb_rst && ((!usba_oe_n && !allow_a) || (!usbb_oe_n && !allow_b))) begin
			fail_run("Transmitter enabled on a port that was not selected");
		end
	end

	// Unselected ports keep the far end's J on pins and line state
	always @(negedge usb_clk) begin
		if (!usb_rst && watch_unsel) begin
			if (!allow_a) begin
				compare_state(pins(0), LS_J, "unselected port A pins");
				compare_state(line_state_a, LS_J, "unselected port A line state");
			end
			if (!allow_b) begin
				compare_state(pins(1), LS_J, "unselected port B pins");
				compare_state(line_state_b, LS_J, "unselected port B line state");
			end
		end
	end

	always @(negedge usb_clk) begin
		if (!usb_rst && !tx_ready) begin
			saw_full = 1'b1;
		end
	end

	// Client writes one byte per cycle while tx_ready allows
	task automatic write_packet(input int first, input int n);
		int cnt;
		for (int i = 0; i < n; i++) begin
			@(posedge usb_clk);
			tx_data  <= 8'(stim[first + i]);
			tx_last  <= (i == n - 1);
			tx_valid <= 1'b1;
			cnt = 0;
			@(negedge usb_clk);
			while (!tx_ready) begin
				cnt++;
				if (cnt > WAIT_LIMIT) begin
					fail_run("Timeout waiting for tx_ready");
				end
				@(negedge usb_clk);
			end
		end
		// Last byte is taken on this edge
		@(posedge usb_clk);
		tx_valid <= 1'b0;
		tx_last  <= 1'b0;
	endtask

	// Line monitor decoding NRZI from J and collecting destuffed bytes LSB first
	task automatic receive_packet(input int p, input int exp_bits);
		int          cnt;
		int          bits;
		int          ones;
		int          nd;
		int          idx;
		logic        prev;
		logic        b;
		line_state_t ls;
		usb_byte_t   cur;
		cnt = 0;
		@(negedge usb_clk);
		while (oe_n_of(p)) begin
			cnt++;
			if (cnt > WAIT_LIMIT) begin
				fail_run($sformatf("Timeout waiting for oe_n low on port %0d", p));
			end
			@(negedge usb_clk);
		end
		// Middle of the first bit
		repeat (2) @(negedge usb_clk);
		prev = 1'b1;
		bits = 0;
		ones = 0;
		nd   = 0;
		idx  = 0;
		cur  = '0;
		ls   = pins(p);
		while (ls != LS_SE0) begin
			if ((ls != LS_J) && (ls != LS_K)) begin
				fail_run("Invalid line level inside a packet");
			end
			b    = (ls[0] == prev);
			prev = ls[0];
			bits++;
			if (ones == `SOFTUSB_STUFF_LIMIT) begin
				// Seven ones in a row would leave the line without a transition
				if (b) begin
					fail_run("Stuffed zero missing after a run of ones");
				end
				ones = 0;
			end else begin
				ones = b ? ones + 1 : 0;
				cur  = {b, cur[7:1]};
				nd++;
				if ((nd % 8) == 0) begin
					if (idx >= exp_q.size()) begin
						fail_run("More bytes on the line than were written");
					end
					compare_byte(cur, exp_q[idx], $sformatf("port %0d byte %0d", p, idx));
					idx++;
				end
			end
			if (bits > MAX_BITS) begin
				fail_run("Packet did not end with SE0");
			end
			repeat (4) @(negedge usb_clk);
			ls = pins(p);
		end
		compare_count(bits, exp_bits, "line bits after stuffing");
		compare_count(idx, exp_q.size(), "bytes received");
		compare_count(nd % 8, 0, "leftover data bits");
		repeat (4) @(negedge usb_clk);
		compare_state(pins(p), LS_SE0, "second EOP bit");
		repeat (4) @(negedge usb_clk);
		// J of the EOP comes from the DUT, not from the far end
		if (oe_n_of(p)) begin
			fail_run("oe_n high during the EOP J bit");
		end
		compare_state(pins(p), LS_J, "EOP J bit");
		repeat (4) @(negedge usb_clk);
		if (!oe_n_of(p)) begin
			fail_run("oe_n still low after EOP");
		end
	endtask

	task automatic run_packet(input int at, output int next);
		port_sel_t sel;
		int        n;
		int        exp_bits;
		sel      = 2'(stim[at + 1]);
		n        = int'(stim[at + 2]);
		exp_bits = int'(stim[at + 3]);
		exp_q.delete();
		for (int i = 0; i < n; i++) begin
			exp_q.push_back(8'(stim[at + 4 + i]));
		end
		@(posedge usb_clk);
		port_sel_tx <= sel;
		allow_a = sel[PORT_A];
		allow_b = sel[PORT_B];
		saw_full = 1'b0;
		watch_unsel = 1'b1;
		fork
			write_packet(at + 4, n);
			begin
				if (sel[PORT_A]) receive_packet(0, exp_bits);
			end
			begin
				if (sel[PORT_B]) receive_packet(1, exp_bits);
			end
		join
		watch_unsel = 1'b0;
		if ((n > `SOFTUSB_FIFO_DEPTH) && !saw_full) begin
			fail_run("tx_ready never fell during a burst longer than the queue");
		end
		next = at + 4 + n;
	endtask

	task automatic run_bus_reset(input port_sel_t sel);
		int cnt;
		@(posedge usb_clk);
		port_sel_tx <= sel;
		allow_a = sel[PORT_A];
		allow_b = sel[PORT_B];
		watch_unsel = 1'b1;
		@(posedge usb_clk);
		generate_reset <= 1'b1;
		repeat (20) @(posedge usb_clk);
		@(negedge usb_clk);
		for (int p = 0; p < 2; p++) begin
			if (sel[p]) begin
				if (oe_n_of(p)) fail_run("oe_n high during bus reset");
				compare_state((p == 0) ? line_state_a : line_state_b, LS_SE0,
					"line state during bus reset");
			end
		end
		repeat (80) @(posedge usb_clk);
		generate_reset <= 1'b0;
		cnt = 0;
		@(negedge usb_clk);
		while (!usba_oe_n || !usbb_oe_n) begin
			cnt++;
			if (cnt > WAIT_LIMIT) fail_run("Timeout waiting for bus reset to end");
			@(negedge usb_clk);
		end
		repeat (4) @(negedge usb_clk);
		compare_state(line_state_a, LS_J, "port A after bus reset");
		compare_state(line_state_b, LS_J, "port B after bus reset");
		watch_unsel = 1'b0;
	endtask

	task automatic run_disconnect(input int p);
		int k;
		allow_a = 1'b0;
		allow_b = 1'b0;
		@(posedge usb_clk);
		if (p == 0) drive_a <= LS_SE0;
		else drive_b <= LS_SE0;
		k = 0;
		forever begin
			@(posedge usb_clk);
			k++;
			@(negedge usb_clk);
			if (discon_of(1 - p)) fail_run("discon raised on the port without SE0");
			if (discon_of(p)) break;
			if (k > WAIT_LIMIT) fail_run("Timeout waiting for discon");
		end
		// Two synchronizer stages ahead of the counter
		compare_count(k, `SOFTUSB_DISCON_CYCLES + 2, "cycles from SE0 to discon");
		@(posedge usb_clk);
		if (p == 0) drive_a <= LS_J;
		else drive_b <= LS_J;
		k = 0;
		@(negedge usb_clk);
		while (discon_of(p)) begin
			k++;
			if (k > 10) fail_run("discon did not clear after J returned");
			@(negedge usb_clk);
		end
	endtask

	initial begin
		int at;
		int cmd;
		usb_clk        = 1'b0;
		usb_rst        = 1'b1;
		port_sel_tx    = '0;
		tx_data        = '0;
		tx_last        = 1'b0;
		tx_valid       = 1'b0;
		generate_reset = 1'b0;
		drive_a        = LS_J;
		drive_b        = LS_J;
		allow_a        = 1'b0;
		allow_b        = 1'b0;
		saw_full       = 1'b0;
		watch_unsel    = 1'b0;
		for (int i = 0; i < 256; i++) begin
			stim[i] = '0;
		end
		$readmemh("softusb_input.txt", stim);

		repeat (16) @(posedge usb_clk);
		usb_rst <= 1'b0;
		repeat (3) @(negedge usb_clk);
		if (!usba_oe_n || !usbb_oe_n) fail_run("oe_n low after reset");
		if (!tx_ready) fail_run("tx_ready low after reset");
		if (usba_discon || usbb_discon) fail_run("discon high after reset");
		if (!usba_spd || !usbb_spd) fail_run("Speed pins not at full speed");

		at  = 0;
		cmd = int'(stim[0]);
		while (cmd != 0) begin
			case (cmd)
				1: run_packet(at, at);
				2: begin
					run_bus_reset(2'(stim[at + 1]));
					at = at + 2;
				end
				3: begin
					run_disconnect(int'(stim[at + 1]) - 1);
					at = at + 2;
				end
				default: fail_run("Unknown command in the data file");
			endcase
			if (at > 250) fail_run("Command list runs past the end of the data file");
			cmd = int'(stim[at]);
		end

		repeat (8) @(posedge usb_clk);
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

/* softusb_input.txt */
// Words in hex: cmd, port_sel or port, byte count, stuffed bit count, bytes
// cmd 1 packet, 2 bus reset on port_sel, 3 disconnect (1 = A, 2 = B), 0 end
0001 0001 0003 0018 0080 0001 00c3
0001 0002 0003 001a 00ff 00ff 0000
0001 0003 0001 0008 003c
0001 0001 0014 00a0
0000 0001 0002 0003 0004 0005 0006 0007 0008 0009
000a 000b 000c 000d 000e 000f 0010 0011 0012 0013
0002 0001
0002 0002
0003 0001
0003 0002
0000

/* verilog.f */
+incdir+.
softusb_pkg.sv
softusb_byte_if.sv
softusb_filter.sv
softusb_tx_fifo.sv
softusb_tx.sv
softusb_linemon.sv
softusb_phy.sv
tb_softusb_phy.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_softusb_phy
OBJ_DIR   ?= obj_dir
FLIST     ?= verilog.f
VFLAGS    ?= --binary --timing -j 0

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard *.sv) softusb_macros.svh $(FLIST)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN) softusb_input.txt
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
